// ==== vlog.f ====
+incdir+.
exUnitPkg.sv
exAddrGen.sv
exAlu.sv
exMul.sv
exMemAccess.sv
exSeq.sv
exUnit.sv
tbExUnit.sv

// ==== Makefile ====
TOP = tbExUnit

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== tbExUnit.sv ====
`include "exUnit_settings.svh"

module tbExUnit;

	localparam int TIMEOUT = 200;	// cycles allowed per wait
	localparam exUnitPkg::regIdT ZZR = `EX_REG_ZZR;

	typedef struct {
		exUnitPkg::opCmdE	cmd;
		exUnitPkg::regIdT	rnId;
		exUnitPkg::wordT	rm, rn, ri;
		exUnitPkg::immT		imm;
		logic				baseRm;
		exUnitPkg::idxSrcE	src;
		logic [1:0]			scale;
		exUnitPkg::regIdT	expId;
		exUnitPkg::wordT	expVal;
		logic				expT;
		exUnitPkg::wordT	expDlr, expDhr;
		logic				memChk;	// row goes through the memory port
		exUnitPkg::wordT	expAddr, expWData;
	} opRowT;

	logic				clock = 1'b0;
	logic				arstN;
	logic				opReq;
	logic				opAck;
	exUnitPkg::opCmdE	opCmd;
	exUnitPkg::regIdT	regIdRn;
	exUnitPkg::wordT	regValRm, regValRn, regValRi;
	exUnitPkg::immT		immVal;
	logic				idxBaseRm;
	exUnitPkg::idxSrcE	idxSrc;
	logic [1:0]			idxScale;
	exUnitPkg::regIdT	regOutId;
	exUnitPkg::wordT	regOutVal;
	logic				srT;
	exUnitPkg::wordT	dlr, dhr;
	logic				memReq;
	logic				memAck = 1'b0;
	logic				memWe;
	exUnitPkg::memSizeE	memSize;
	exUnitPkg::wordT	memAddr, memWData;
	exUnitPkg::wordT	memRData = '0;

	opRowT				rows[$];
	exUnitPkg::wordT	memModel[16];
	exUnitPkg::wordT	seenAddr, seenWData;
	exUnitPkg::memSizeE	seenSize;
	logic				seenWe;
	logic				tExp;
	exUnitPkg::wordT	dExp, hExp;
	logic [31:0]		lfsr = 32'hd87c;
	logic				reqBusy = 1'b0;
	int					ackDelay = 0;
	int					ackHold = 0;
	int					errCount = 0;
	int					toCount = 0;
	int					curRow = -1;

	exUnit u_dut (.*);

	always #10 clock = ~clock;

	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
	endfunction

	function automatic int randBits(int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsrNext(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	// byte count of the access named by a load or store opcode
	function automatic exUnitPkg::memSizeE accessSize(exUnitPkg::opCmdE cmd);
		if (cmd inside {exUnitPkg::STB, exUnitPkg::LDB, exUnitPkg::LDUB})
			return exUnitPkg::B;
		else if (cmd inside {exUnitPkg::STW, exUnitPkg::LDW, exUnitPkg::LDUW})
			return exUnitPkg::W;
		else if (cmd inside {exUnitPkg::STL, exUnitPkg::LDL, exUnitPkg::LDUL})
			return exUnitPkg::L;
		else
			return exUnitPkg::Q;
	endfunction

	task automatic checkWord(string name, exUnitPkg::wordT got, exUnitPkg::wordT exp);
		if (got !== exp) begin
			$display("Error row %0d: %s got %h, expected %h", curRow, name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkId(string name, exUnitPkg::regIdT got, exUnitPkg::regIdT exp);
		if (got !== exp) begin
			$display("Error row %0d: %s got %h, expected %h", curRow, name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Error row %0d: %s got %h, expected %h", curRow, name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkSize(string name, exUnitPkg::memSizeE got, exUnitPkg::memSizeE exp);
		if (got !== exp) begin
			$display("Error row %0d: %s got %h, expected %h", curRow, name, got, exp);
			errCount++;
		end
	endtask

	// memory side of the four-phase handshake with an ack after 0 to 3 random cycles
	task automatic serveAccess();
		exUnitPkg::wordT mask;
		logic [3:0] idx;
		idx = memAddr[6:3];
		seenAddr = memAddr;
		seenWData = memWData;
		seenSize = memSize;
		seenWe = memWe;
		case (memSize)
			exUnitPkg::B:	mask = 64'hff;
			exUnitPkg::W:	mask = 64'hffff;
			exUnitPkg::L:	mask = 64'hffff_ffff;
			default:		mask = 64'hffff_ffff_ffff_ffff;
		endcase
		if (memWe)
			memModel[idx] = (memModel[idx] & ~mask) | (memWData & mask);
		else
			memRData = memModel[idx];
	endtask

	always @(posedge clock) begin
		#2;
		if (memAck) begin
			if (!memReq) begin
				memAck = 1'b0;
			end else begin
				ackHold++;
				if (ackHold == TIMEOUT) begin
					$display("Timeout: memReq never dropped after memAck");
					toCount++;
				end
			end
		end else if (memReq && arstN) begin
			if (!reqBusy) begin
				reqBusy = 1'b1;
				ackDelay = randBits(2);
			end
			if (ackDelay == 0) begin
				serveAccess();
				memAck = 1'b1;
				reqBusy = 1'b0;
				ackHold = 0;
			end else begin
				ackDelay--;
			end
		end
	end

	task automatic addrRow(exUnitPkg::opCmdE cmd, exUnitPkg::regIdT rnId,
		exUnitPkg::wordT rm, exUnitPkg::wordT rn, exUnitPkg::wordT ri, exUnitPkg::immT imm,
		logic baseRm, exUnitPkg::idxSrcE src, logic [1:0] scale,
		exUnitPkg::regIdT expId, exUnitPkg::wordT expVal, exUnitPkg::wordT expAddr);
		rows.push_back(opRowT'{cmd, rnId, rm, rn, ri, imm, baseRm, src, scale, expId, expVal,
			tExp, dExp, hExp, cmd inside {[exUnitPkg::LDB:exUnitPkg::STQ]}, expAddr, rm});
	endtask

	task automatic aluRow(exUnitPkg::opCmdE cmd, exUnitPkg::regIdT rnId,
		exUnitPkg::wordT rm, exUnitPkg::wordT rn, exUnitPkg::wordT ri, exUnitPkg::immT imm,
		exUnitPkg::regIdT expId, exUnitPkg::wordT expVal);
		addrRow(cmd, rnId, rm, rn, ri, imm, 1'b0, exUnitPkg::NONE, 2'd0, expId, expVal, '0);
	endtask

	// product halves land in DLR and DHR and are sign-extended only for MULS
	task automatic setMulExp(logic [31:0] x, logic [31:0] y, logic sgn);
		exUnitPkg::wordT p;
		if (sgn)
			p = {{32{x[31]}}, x} * {{32{y[31]}}, y};
		else
			p = {32'b0, x} * {32'b0, y};
		dExp = {{32{sgn & p[31]}}, p[31:0]};
		hExp = {{32{sgn & p[63]}}, p[63:32]};
	endtask

	task automatic buildTable();
		exUnitPkg::wordT a;
		exUnitPkg::wordT b;
		tExp = 1'b0;
		dExp = '0;
		hExp = '0;
		aluRow(exUnitPkg::ADD, 1, 64'hffff_ffff, 0, 1, 0, 1, 64'h1_0000_0000);	// carry past bit 31
		aluRow(exUnitPkg::SUB, 2, 64'h1_0000_0000, 0, 1, 0, 2, 64'hffff_ffff);
		a = 64'hf0f0_1234_5678_9abc;
		b = 64'h0ff0_ff00_00ff_f00f;
		aluRow(exUnitPkg::AND, 3, a, 0, b, 0, 3, a & b);
		aluRow(exUnitPkg::OR, 4, a, 0, b, 0, 4, a | b);
		aluRow(exUnitPkg::XOR, 5, a, 0, b, 0, 5, a ^ b);
		aluRow(exUnitPkg::CSELT, 6, a, 0, b, 0, 6, b);	// T clear picks Ri
		tExp = 1'b1;
		aluRow(exUnitPkg::ADC, 7, 64'hffff_ffff_ffff_ffff, 0, 1, 0, 7, 0);
		aluRow(exUnitPkg::CSELT, 8, a, 0, b, 0, 8, a);
		tExp = 1'b0;
		aluRow(exUnitPkg::ADC, 9, 5, 0, 6, 0, 9, 12);	// T carried in
		tExp = 1'b1;
		aluRow(exUnitPkg::SBB, 10, 10, 0, 3, 0, 10, 6);	// T clear borrows one
		tExp = 1'b0;
		aluRow(exUnitPkg::SBB, 11, 2, 0, 5, 0, 11, 64'hffff_ffff_ffff_fffd);
		// compares of Rn against Rm
		tExp = 1'b1;
		aluRow(exUnitPkg::CMPEQ, 12, 64'h5555_0000_0000_1234, 64'haaaa_0000_0000_1234, 0, 0,
			ZZR, 0);
		tExp = 1'b0;
		aluRow(exUnitPkg::CMPQEQ, 12, 64'h5555_0000_0000_1234, 64'haaaa_0000_0000_1234, 0, 0,
			ZZR, 0);
		tExp = 1'b1;
		aluRow(exUnitPkg::CMPHI, 12, 64'h7fff_ffff, 64'h8000_0000, 0, 0, ZZR, 0);
		tExp = 1'b0;
		aluRow(exUnitPkg::CMPGT, 12, 64'h7fff_ffff, 64'h8000_0000, 0, 0, ZZR, 0);
		tExp = 1'b1;
		aluRow(exUnitPkg::CMPGT, 12, 64'hffff_ffff, 5, 0, 0, ZZR, 0);	// 5 > -1
		aluRow(exUnitPkg::CMPQHI, 12, 64'hffff_ffff, 64'h1_0000_0000, 0, 0, ZZR, 0);
		tExp = 1'b0;
		aluRow(exUnitPkg::CMPHI, 12, 64'hffff_ffff, 64'h1_0000_0000, 0, 0, ZZR, 0);
		tExp = 1'b1;
		aluRow(exUnitPkg::TST, 12, 64'h00ff_0000_0000_000f, 64'hff00_0000_0000_00f0, 0, 0,
			ZZR, 0);
		tExp = 1'b0;
		aluRow(exUnitPkg::TSTQ, 12, 64'hff00_0000_0000_0000, 64'hff00_0000_0000_00f0, 0, 0,
			ZZR, 0);
		dExp = 64'hffff_ffff_8000_0000;
		aluRow(exUnitPkg::LDIX, 13, 0, 0, 0, 33'h1_8000_0000, ZZR, 0);
		dExp = {dExp[55:0], 8'hab};
		aluRow(exUnitPkg::LDISH, 13, 0, 0, 0, 33'h0_0000_01ab, ZZR, 0);
		dExp = {dExp[47:0], 16'h1234};
		aluRow(exUnitPkg::LDISH16, 13, 0, 0, 0, 33'h0_5678_1234, ZZR, 0);
		a = 64'h1000;
		addrRow(exUnitPkg::LEA, 14, a, 0, 0, 0, 1, exUnitPkg::NONE, 0, 14, a, 0);
		addrRow(exUnitPkg::LEA, 14, a, 0, 0, 0, 1, exUnitPkg::DLR, 1, 14, a + (dExp << 1), 0);
		addrRow(exUnitPkg::LEA, 14, a, 0, 0, 33'h1_ffff_fffc, 1, exUnitPkg::IMM, 2, 14,
			a - 64'd16, 0);
		addrRow(exUnitPkg::LEA, 15, 0, 64'hffff_fffd, 1, 0, 0, exUnitPkg::RI, 3, 15,
			64'h1_0000_0005, 0);
		// stores based on Rn with data from Rm
		addrRow(exUnitPkg::STQ, 16, 64'h8877_6655_4433_2211, 64'h100, 1, 0, 0, exUnitPkg::RI,
			3, ZZR, 0, 64'h108);
		addrRow(exUnitPkg::STL, 16, 64'hdead_beef_8765_4321, 64'h100, 0, 33'h10, 0,
			exUnitPkg::IMM, 0, ZZR, 0, 64'h110);
		addrRow(exUnitPkg::STW, 16, 64'h1111_2222_3333_c0de, 64'h100, 0, 33'h6, 0,
			exUnitPkg::IMM, 2, ZZR, 0, 64'h118);
		addrRow(exUnitPkg::STB, 16, 64'h7777_6666_5555_4480, 64'h100, 0, 33'h4, 0,
			exUnitPkg::IMM, 3, ZZR, 0, 64'h120);
		a = 64'h100;
		addrRow(exUnitPkg::LDQ, 17, a, 0, 0, 33'h8, 1, exUnitPkg::IMM, 0, 17,
			64'h8877_6655_4433_2211, 64'h108);
		addrRow(exUnitPkg::LDL, 17, a, 0, 0, 33'h10, 1, exUnitPkg::IMM, 0, 17,
			64'hffff_ffff_8765_4321, 64'h110);
		addrRow(exUnitPkg::LDUL, 17, a, 0, 0, 33'h10, 1, exUnitPkg::IMM, 0, 17,
			64'h8765_4321, 64'h110);
		addrRow(exUnitPkg::LDW, 17, a, 0, 0, 33'h18, 1, exUnitPkg::IMM, 0, 17,
			64'hffff_ffff_ffff_c0de, 64'h118);
		addrRow(exUnitPkg::LDUW, 17, a, 0, 0, 33'h18, 1, exUnitPkg::IMM, 0, 17,
			64'hc0de, 64'h118);
		addrRow(exUnitPkg::LDB, 17, a, 0, 0, 33'h20, 1, exUnitPkg::IMM, 0, 17,
			64'hffff_ffff_ffff_ff80, 64'h120);
		addrRow(exUnitPkg::LDUB, 17, a, 0, 0, 33'h20, 1, exUnitPkg::IMM, 0, 17,
			64'h80, 64'h120);
		addrRow(exUnitPkg::LDB, 17, a, 0, 0, 33'h10, 1, exUnitPkg::IMM, 0, 17,
			64'h21, 64'h110);
		// multiplier takes the low halves of Rn and Rm
		setMulExp(32'hffff_ffff, 32'h2, 1'b0);
		aluRow(exUnitPkg::MULU, 18, 2, 64'hffff_ffff, 0, 0, ZZR, 0);
		setMulExp(32'hffff_ffff, 32'h2, 1'b1);
		aluRow(exUnitPkg::MULS, 18, 2, 64'hffff_ffff, 0, 0, ZZR, 0);
		setMulExp(32'h1234_5678, 32'hffff_f000, 1'b1);
		aluRow(exUnitPkg::MULS, 18, 64'hffff_f000, 64'h1234_5678, 0, 0, ZZR, 0);
		setMulExp(32'h8000_0001, 32'h8000_0001, 1'b0);
		aluRow(exUnitPkg::MULU, 18, 64'h8000_0001, 64'h8000_0001, 0, 0, ZZR, 0);
		setMulExp(32'h8000_0000, 32'h8000_0000, 1'b1);
		aluRow(exUnitPkg::MULS, 18, 64'h8000_0000, 64'h8000_0000, 0, 0, ZZR, 0);
	endtask

	// one table row through the four-phase op handshake
	task automatic applyRow(int i);
		opRowT r;
		int n;
		r = rows[i];
		curRow = i;
		seenAddr = '0;
		seenWData = '0;
		opCmd = r.cmd;
		regIdRn = r.rnId;
		regValRm = r.rm;
		regValRn = r.rn;
		regValRi = r.ri;
		immVal = r.imm;
		idxBaseRm = r.baseRm;
		idxSrc = r.src;
		idxScale = r.scale;
		opReq = 1'b1;
		n = 0;
		while (!opAck && n < TIMEOUT) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (!opAck) begin
			$display("Timeout: row %0d never got opAck", i);
			toCount++;
		end else begin
			checkId("regOutId", regOutId, r.expId);
			if (r.expId != ZZR)
				checkWord("regOutVal", regOutVal, r.expVal);
			checkBit("srT", srT, r.expT);
			checkWord("dlr", dlr, r.expDlr);
			checkWord("dhr", dhr, r.expDhr);
			if (r.memChk) begin
				checkWord("memAddr", seenAddr, r.expAddr);
				checkSize("memSize", seenSize, accessSize(r.cmd));
				checkBit("memWe", seenWe, r.cmd inside {[exUnitPkg::STB:exUnitPkg::STQ]});
				if (r.cmd inside {[exUnitPkg::STB:exUnitPkg::STQ]})
					checkWord("memWData", seenWData, r.expWData);
			end
			opReq = 1'b0;
			n = 0;
			while (opAck && n < TIMEOUT) begin
				@(posedge clock);
				#2;
				n++;
			end
			if (opAck) begin
				$display("Timeout: row %0d opAck stuck high", i);
				toCount++;
			end
		end
	endtask

	initial begin
		arstN = 1'b0;
		opReq = 1'b0;
		opCmd = exUnitPkg::NOP;
		regIdRn = '0;
		regValRm = '0;
		regValRn = '0;
		regValRi = '0;
		immVal = '0;
		idxBaseRm = 1'b0;
		idxSrc = exUnitPkg::NONE;
		idxScale = '0;
		for (int i = 0; i < 16; i++)
			memModel[i] = 64'h0123_4567_89ab_cdef ^ {16{4'(i)}};
		buildTable();
		repeat (10) @(posedge clock);
		#2;
		checkBit("opAck", opAck, 1'b0);	// reset state
		checkBit("memReq", memReq, 1'b0);
		checkBit("srT", srT, 1'b0);
		checkWord("dlr", dlr, '0);
		checkWord("dhr", dhr, '0);
		arstN = 1'b1;
		for (int i = 0; i < rows.size() && toCount == 0; i++)
			applyRow(i);
		$display("errors %0d, timeouts %0d", errCount, toCount);
		if (errCount == 0 && toCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== exUnit.sv ====
`include "exUnit_settings.svh"

module exUnit (
	input  logic				clock,
	input  logic				arstN,
	input  logic				opReq,
	output logic				opAck,
	input  exUnitPkg::opCmdE	opCmd,
	input  exUnitPkg::regIdT	regIdRn,
	input  exUnitPkg::wordT		regValRm, regValRn, regValRi,
	input  exUnitPkg::immT		immVal,
	input  logic				idxBaseRm,
	input  exUnitPkg::idxSrcE	idxSrc,
	input  logic [1:0]			idxScale,
	output exUnitPkg::regIdT	regOutId,
	output exUnitPkg::wordT		regOutVal,
	output logic				srT,
	output exUnitPkg::wordT		dlr, dhr,
	output logic				memReq,
	input  logic				memAck,
	output logic				memWe,
	output exUnitPkg::memSizeE	memSize,
	output exUnitPkg::wordT		memAddr,
	output exUnitPkg::wordT		memWData,
	input  exUnitPkg::wordT		memRData
);

	exUnitPkg::opCmdE	capCmd;
	exUnitPkg::wordT	capRm, capRn, capRi;
	exUnitPkg::immT		capImm;
	logic				capBaseRm;
	exUnitPkg::idxSrcE	capIdxSrc;
	logic [1:0]			capIdxScale;
	exUnitPkg::wordT	aluVal, newDlr, effAddr, loadVal;
	logic				aluWrRn, newT, dlrWe;
	logic				mulStart, mulSigned, mulDone;
	exUnitPkg::halfT	mulLo, mulHi;
	logic				memStart, memWrite, loadSigned, memDone;
	exUnitPkg::memSizeE	memSizeSel;

	exSeq u_seq (.*);

	exAlu u_alu (
		.opCmd(capCmd), .regValRm(capRm), .regValRn(capRn), .regValRi(capRi),
		.immVal(capImm), .dlr, .srT, .aluVal, .aluWrRn, .newT, .newDlr, .dlrWe
	);

	exAddrGen u_addrGen (
		.idxBaseRm(capBaseRm), .idxSrc(capIdxSrc), .idxScale(capIdxScale),
		.regValRm(capRm), .regValRn(capRn), .regValRi(capRi),
		.dlr, .immVal(capImm), .effAddr
	);

	// MULU and MULS take the low halves of Rn and Rm
	exMul u_mul (
		.clock, .arstN, .mulStart, .mulSigned,
		.mulA(capRn[`EX_HALF-1:0]), .mulB(capRm[`EX_HALF-1:0]),
		.mulDone, .mulLo, .mulHi
	);

	exMemAccess u_memAccess (
		.clock, .arstN, .memStart, .memWrite, .memSizeSel, .loadSigned,
		.effAddr, .storeVal(capRm), .memDone, .loadVal,
		.memReq, .memAck, .memWe, .memSize, .memAddr, .memWData, .memRData
	);

endmodule

// ==== exSeq.sv ====
`include "exUnit_settings.svh"

module exSeq (
	input  logic				clock,
	input  logic				arstN,
	input  logic				opReq,
	output logic				opAck,
	input  exUnitPkg::opCmdE	opCmd,
	input  exUnitPkg::regIdT	regIdRn,
	input  exUnitPkg::wordT		regValRm, regValRn, regValRi,
	input  exUnitPkg::immT		immVal,
	input  logic				idxBaseRm,
	input  exUnitPkg::idxSrcE	idxSrc,
	input  logic [1:0]			idxScale,
	output exUnitPkg::opCmdE	capCmd,
	output exUnitPkg::wordT		capRm, capRn, capRi,
	output exUnitPkg::immT		capImm,
	output logic				capBaseRm,
	output exUnitPkg::idxSrcE	capIdxSrc,
	output logic [1:0]			capIdxScale,
	input  exUnitPkg::wordT		aluVal, newDlr, effAddr, loadVal,
	input  logic				aluWrRn, newT, dlrWe,
	input  logic				mulDone,
	input  exUnitPkg::halfT		mulLo, mulHi,
	input  logic				memDone,
	output logic				mulStart, mulSigned,
	output logic				memStart, memWrite, loadSigned,
	output exUnitPkg::memSizeE	memSizeSel,
	output exUnitPkg::regIdT	regOutId,
	output exUnitPkg::wordT		regOutVal,
	output logic				srT,
	output exUnitPkg::wordT		dlr, dhr
);

	exUnitPkg::seqStateE	state;
	exUnitPkg::regIdT		capRnId;
	logic					isMul;
	logic					isMem;

	function automatic exUnitPkg::wordT extHalf(exUnitPkg::halfT h, logic sgn);
		return {{(`EX_XLEN-`EX_HALF){sgn & h[`EX_HALF-1]}}, h};
	endfunction

	// unit selection from the captured opcode
	assign isMul = capCmd inside {exUnitPkg::MULU, exUnitPkg::MULS};
	assign mulSigned = capCmd == exUnitPkg::MULS;
	assign memWrite = capCmd inside {exUnitPkg::STB, exUnitPkg::STW, exUnitPkg::STL,
		exUnitPkg::STQ};
	assign loadSigned = capCmd inside {exUnitPkg::LDB, exUnitPkg::LDW, exUnitPkg::LDL,
		exUnitPkg::LDQ};
	assign isMem = memWrite || loadSigned
		|| capCmd inside {exUnitPkg::LDUB, exUnitPkg::LDUW, exUnitPkg::LDUL};

	always_comb begin
		case (capCmd)
			exUnitPkg::LDB, exUnitPkg::LDUB, exUnitPkg::STB:	memSizeSel = exUnitPkg::B;
			exUnitPkg::LDW, exUnitPkg::LDUW, exUnitPkg::STW:	memSizeSel = exUnitPkg::W;
			exUnitPkg::LDL, exUnitPkg::LDUL, exUnitPkg::STL:	memSizeSel = exUnitPkg::L;
			default:											memSizeSel = exUnitPkg::Q;
		endcase
	end

	assign mulStart = state == exUnitPkg::EXEC && isMul;	// one cycle pulse
	assign memStart = state == exUnitPkg::EXEC && isMem;

	always_ff @(posedge clock) begin
		if (state == exUnitPkg::IDLE && opReq) begin
			capCmd <= opCmd;
			capRnId <= regIdRn;
			capRm <= regValRm;
			capRn <= regValRn;
			capRi <= regValRi;
			capImm <= immVal;
			capBaseRm <= idxBaseRm;
			capIdxSrc <= idxSrc;
			capIdxScale <= idxScale;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= exUnitPkg::IDLE;
			opAck <= 1'b0;
			regOutId <= `EX_REG_ZZR;
			regOutVal <= '0;
			srT <= 1'b0;
			dlr <= '0;
			dhr <= '0;
		end else begin
			case (state)
				exUnitPkg::IDLE: if (opReq)
					state <= exUnitPkg::EXEC;
				exUnitPkg::EXEC: if (isMul || isMem) begin
					state <= exUnitPkg::WAITUNIT;
				end else begin
					regOutId <= (aluWrRn || capCmd == exUnitPkg::LEA) ? capRnId : `EX_REG_ZZR;
					regOutVal <= capCmd == exUnitPkg::LEA ? effAddr : aluVal;
					srT <= newT;
					if (dlrWe)
						dlr <= newDlr;
					opAck <= 1'b1;
					state <= exUnitPkg::ACK;
				end
				exUnitPkg::WAITUNIT: if (mulDone) begin
					dlr <= extHalf(mulLo, mulSigned);
					dhr <= extHalf(mulHi, mulSigned);
					regOutId <= `EX_REG_ZZR;
					opAck <= 1'b1;
					state <= exUnitPkg::ACK;
				end else if (memDone) begin
					regOutId <= memWrite ? `EX_REG_ZZR : capRnId;
					regOutVal <= loadVal;
					opAck <= 1'b1;
					state <= exUnitPkg::ACK;
				end
				default: if (!opReq) begin	// requester let go
					opAck <= 1'b0;
					state <= exUnitPkg::IDLE;
				end
			endcase
		end
	end

	// opReq must have been high on the edge that raised opAck
	ackNeedsReq: assert property (@(posedge clock) disable iff (!arstN)
		$rose(opAck) |-> $past(opReq));

endmodule

// ==== exMemAccess.sv ====
`include "exUnit_settings.svh"

module exMemAccess (
	input  logic				clock,
	input  logic				arstN,
	input  logic				memStart,
	input  logic				memWrite,
	input  exUnitPkg::memSizeE	memSizeSel,
	input  logic				loadSigned,
	input  exUnitPkg::wordT		effAddr,
	input  exUnitPkg::wordT		storeVal,
	output logic				memDone,
	output exUnitPkg::wordT		loadVal,
	output logic				memReq,
	input  logic				memAck,
	output logic				memWe,
	output exUnitPkg::memSizeE	memSize,
	output exUnitPkg::wordT		memAddr,
	output exUnitPkg::wordT		memWData,
	input  exUnitPkg::wordT		memRData
);

	typedef enum logic [1:0] {
		IDLE, WAITHIGH, WAITLOW
	} memStateE;

	memStateE			state;
	logic				sgnQ;
	exUnitPkg::wordT	rdataQ;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			memReq <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (state)
				IDLE: if (memStart) begin
					memReq <= 1'b1;
					state <= WAITHIGH;
				end
				WAITHIGH: if (memAck) begin
					memReq <= 1'b0;
					state <= WAITLOW;
				end
				default: if (!memAck) begin	// ack dropped so the cycle is over
					memDone <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && memStart) begin
			memAddr <= effAddr;
			memWData <= storeVal;
			memWe <= memWrite;
			memSize <= memSizeSel;
			sgnQ <= loadSigned;
		end
		if (state == WAITHIGH && memAck)
			rdataQ <= memRData;
	end

	always_comb begin
		case (memSize)
			exUnitPkg::B:	loadVal = {{(`EX_XLEN-8){sgnQ & rdataQ[7]}}, rdataQ[7:0]};
			exUnitPkg::W:	loadVal = {{(`EX_XLEN-16){sgnQ & rdataQ[15]}}, rdataQ[15:0]};
			exUnitPkg::L:	loadVal = {{(`EX_XLEN-`EX_HALF){sgnQ & rdataQ[`EX_HALF-1]}},
				rdataQ[`EX_HALF-1:0]};
			default:		loadVal = rdataQ;
		endcase
	end

	addrHeld: assert property (@(posedge clock) disable iff (!arstN)
		memReq |=> !memReq || $stable(memAddr));

endmodule

// ==== exMul.sv ====
`include "exUnit_settings.svh"

module exMul (
	input  logic				clock,
	input  logic				arstN,
	input  logic				mulStart,
	input  logic				mulSigned,
	input  exUnitPkg::halfT		mulA,
	input  exUnitPkg::halfT		mulB,
	output logic				mulDone,
	output exUnitPkg::halfT		mulLo,
	output exUnitPkg::halfT		mulHi
);

	localparam int P = `EX_HALF / 2;	// partial product operand width

	logic				v1;
	logic				v2;
	logic				sgn1;
	exUnitPkg::halfT	a1;
	exUnitPkg::halfT	b1;
	exUnitPkg::halfT	ppLL;
	exUnitPkg::halfT	ppLH;
	exUnitPkg::halfT	ppHL;
	exUnitPkg::halfT	ppHH;
	exUnitPkg::halfT	corr;

	// valid bits march alongside the data
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			mulDone <= 1'b0;
		end else begin
			v1 <= mulStart;
			v2 <= v1;
			mulDone <= v2;
		end
	end

	always_ff @(posedge clock) begin
		a1 <= mulA;	// stage 1
		b1 <= mulB;
		sgn1 <= mulSigned;
		ppLL <= a1[P-1:0] * b1[P-1:0];	// stage 2
		ppLH <= a1[P-1:0] * b1[2*P-1:P];
		ppHL <= a1[2*P-1:P] * b1[P-1:0];
		ppHH <= a1[2*P-1:P] * b1[2*P-1:P];
		// negative operand subtracts the other one from the high half
		corr <= sgn1 ? ((a1[`EX_HALF-1] ? -b1 : '0) + (b1[`EX_HALF-1] ? -a1 : '0)) : '0;
		{mulHi, mulLo} <= {{`EX_HALF{1'b0}}, ppLL}	// stage 3
			+ {{P{1'b0}}, ppLH, {P{1'b0}}}
			+ {{P{1'b0}}, ppHL, {P{1'b0}}}
			+ {ppHH, {`EX_HALF{1'b0}}}
			+ {corr, {`EX_HALF{1'b0}}};
	end

	mulLatency: assert property (@(posedge clock) disable iff (!arstN)
		mulStart |-> ##3 mulDone);

endmodule

// ==== exAlu.sv ====
`include "exUnit_settings.svh"

module exAlu (
	input  exUnitPkg::opCmdE	opCmd,
	input  exUnitPkg::wordT		regValRm,
	input  exUnitPkg::wordT		regValRn,
	input  exUnitPkg::wordT		regValRi,
	input  exUnitPkg::immT		immVal,
	input  exUnitPkg::wordT		dlr,
	input  logic				srT,
	output exUnitPkg::wordT		aluVal,
	output logic				aluWrRn,
	output logic				newT,
	output exUnitPkg::wordT		newDlr,
	output logic				dlrWe
);

	exUnitPkg::wordT	addB;
	exUnitPkg::wordT	addSum;
	logic				addCin;
	logic				addCout;
	logic				gtU32;

	// shared adder for ADD, SUB, ADC and SBB
	always_comb begin
		addB = (opCmd inside {exUnitPkg::SUB, exUnitPkg::SBB}) ? ~regValRi : regValRi;
		case (opCmd)
			exUnitPkg::SUB:					addCin = 1'b1;
			exUnitPkg::ADC, exUnitPkg::SBB:	addCin = srT;	// SBB borrows on !T
			default:						addCin = 1'b0;
		endcase
		{addCout, addSum} = {1'b0, regValRm} + {1'b0, addB} + addCin;
	end

	assign gtU32 = regValRn[`EX_HALF-1:0] > regValRm[`EX_HALF-1:0];

	assign aluWrRn = opCmd inside {exUnitPkg::MOVRR, exUnitPkg::MOVIR, exUnitPkg::ADD,
		exUnitPkg::SUB, exUnitPkg::ADC, exUnitPkg::SBB, exUnitPkg::AND, exUnitPkg::OR,
		exUnitPkg::XOR, exUnitPkg::CSELT};

	always_comb begin
		case (opCmd)
			exUnitPkg::MOVIR:	aluVal = exUnitPkg::sextImm(immVal);
			exUnitPkg::ADD, exUnitPkg::SUB, exUnitPkg::ADC, exUnitPkg::SBB:
				aluVal = addSum;
			exUnitPkg::AND:		aluVal = regValRm & regValRi;
			exUnitPkg::OR:		aluVal = regValRm | regValRi;
			exUnitPkg::XOR:		aluVal = regValRm ^ regValRi;
			exUnitPkg::CSELT:	aluVal = srT ? regValRm : regValRi;
			default:			aluVal = regValRm;	// MOVRR
		endcase
	end

	always_comb begin
		case (opCmd)
			exUnitPkg::ADC, exUnitPkg::SBB:	newT = addCout;
			exUnitPkg::TST:		newT = (regValRn[`EX_HALF-1:0] & regValRm[`EX_HALF-1:0]) == '0;
			exUnitPkg::TSTQ:	newT = (regValRn & regValRm) == '0;
			exUnitPkg::CMPEQ:	newT = regValRn[`EX_HALF-1:0] == regValRm[`EX_HALF-1:0];
			exUnitPkg::CMPHI:	newT = gtU32;
			// signs differ flips the unsigned answer
			exUnitPkg::CMPGT:	newT = gtU32 ^ (regValRn[`EX_HALF-1] ^ regValRm[`EX_HALF-1]);
			exUnitPkg::CMPQEQ:	newT = regValRn == regValRm;
			exUnitPkg::CMPQHI:	newT = regValRn > regValRm;
			default:			newT = srT;
		endcase
	end

	always_comb begin
		dlrWe = 1'b1;
		case (opCmd)
			exUnitPkg::LDIX:	newDlr = exUnitPkg::sextImm(immVal);
			exUnitPkg::LDISH:	newDlr = {dlr[`EX_XLEN-9:0], immVal[7:0]};
			exUnitPkg::LDISH16:	newDlr = {dlr[`EX_XLEN-17:0], immVal[15:0]};
			default: begin
				newDlr = dlr;
				dlrWe = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (!$isunknown(opCmd))
			assert (opCmd <= exUnitPkg::STQ)
				else $error("exAlu: opcode %0h outside opCmdE", opCmd);
	end

endmodule

// ==== exAddrGen.sv ====
`include "exUnit_settings.svh"

module exAddrGen (
	input  logic				idxBaseRm,
	input  exUnitPkg::idxSrcE	idxSrc,
	input  logic [1:0]			idxScale,
	input  exUnitPkg::wordT		regValRm,
	input  exUnitPkg::wordT		regValRn,
	input  exUnitPkg::wordT		regValRi,
	input  exUnitPkg::wordT		dlr,
	input  exUnitPkg::immT		immVal,
	output exUnitPkg::wordT		effAddr
);

	exUnitPkg::wordT	base;
	exUnitPkg::wordT	index;
	exUnitPkg::wordT	scaled;
	logic [`EX_HALF:0]	sumLo;	// carry in top bit
	exUnitPkg::halfT	sumHi0;
	exUnitPkg::halfT	sumHi1;

	always_comb begin
		base = idxBaseRm ? regValRm : regValRn;
		case (idxSrc)
			exUnitPkg::DLR:	index = dlr;
			exUnitPkg::IMM:	index = exUnitPkg::sextImm(immVal);
			exUnitPkg::RI:	index = regValRi;
			default:		index = '0;	// base only
		endcase
		scaled = index << idxScale;
	end

	// both high sums ready before the low carry settles
	assign sumLo = {1'b0, base[`EX_HALF-1:0]} + {1'b0, scaled[`EX_HALF-1:0]};
	assign sumHi0 = base[`EX_XLEN-1:`EX_HALF] + scaled[`EX_XLEN-1:`EX_HALF];
	assign sumHi1 = base[`EX_XLEN-1:`EX_HALF] + scaled[`EX_XLEN-1:`EX_HALF] + 1'b1;

	assign effAddr = {sumLo[`EX_HALF] ? sumHi1 : sumHi0, sumLo[`EX_HALF-1:0]};

endmodule

// ==== exUnitPkg.sv ====
`include "exUnit_settings.svh"

package exUnitPkg;

	typedef logic [`EX_XLEN-1:0]	wordT;
	typedef logic [`EX_HALF-1:0]	halfT;
	typedef logic [`EX_REGID_W-1:0]	regIdT;
	typedef logic [`EX_IMM_W-1:0]	immT;

	typedef enum logic [5:0] {
		NOP, MOVRR, MOVIR,
		ADD, SUB, ADC, SBB, AND, OR, XOR, CSELT,
		TST, TSTQ, CMPEQ, CMPHI, CMPGT, CMPQEQ, CMPQHI,
		LDIX, LDISH, LDISH16,
		LEA,
		MULU, MULS,
		LDB, LDW, LDL, LDQ, LDUB, LDUW, LDUL,
		STB, STW, STL, STQ
	} opCmdE;

	typedef enum logic [1:0] {
		B, W, L, Q
	} memSizeE;

	typedef enum logic [1:0] {
		NONE, DLR, IMM, RI
	} idxSrcE;

	typedef enum logic [1:0] {
		IDLE, EXEC, WAITUNIT, ACK
	} seqStateE;

	// immediate widened to a full word
	function automatic wordT sextImm(immT v);
		return {{(`EX_XLEN-`EX_IMM_W){v[`EX_IMM_W-1]}}, v};
	endfunction

endpackage

// ==== exUnit_settings.svh ====
`ifndef EX_UNIT_SETTINGS_SVH
`define EX_UNIT_SETTINGS_SVH

// datapath widths
`define EX_XLEN		64
`define EX_HALF		32	// carry split point and multiplier operand
`define EX_REGID_W	7
`define EX_IMM_W	33	// immediate with its sign bit

// null register id that writes nothing
`define EX_REG_ZZR	7'h7F

`endif
